// File: source/fetch_pkg.sv
package fetch_pkg;

	typedef logic [31:0] addr_t;    // byte address of an instruction
	typedef logic [63:0] line_t;    // one fetch line, four halfwords
	typedef logic [15:0] hword_t;   // one 16-bit parcel
	typedef logic [31:0] instr_t;   // parcels from the instruction pc upward
	typedef logic [3:0]  hw_ptr_t;  // halfword count in the buffer

	localparam int BUF_HWORDS  = 15;
	localparam int LINE_HWORDS = 4;

	// travels with a request and comes back with the line
	typedef struct packed {
		logic       epoch;
		logic [1:0] hw_offset;  // first useful halfword
	} fetch_tag_t;

	typedef struct packed {
		addr_t      addr;       // always 8-byte aligned
		fetch_tag_t tag;
	} fetch_req_t;

	typedef struct packed {
		line_t      line;
		fetch_tag_t tag;        // echoed copy
	} fetch_resp_t;

	// one decoder slot
	typedef struct packed {
		logic   valid;
		addr_t  pc;
		instr_t instr;
	} issue_slot_t;

endpackage

// File: source/fetch_addr_gen.sv
`timescale 1ns/1ps

module fetch_addr_gen #(
	parameter fetch_pkg::addr_t RESET_PC      = 32'h0000_1000,
	parameter int               FETCH_CREDITS = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  redirect,
	input  fetch_pkg::addr_t      redirect_pc,
	input  logic                  line_done,
	output logic                  req_valid,
	output fetch_pkg::fetch_req_t req,
	output logic                  epoch
);
	import fetch_pkg::*;

	localparam int CNT_W = $clog2(FETCH_CREDITS + 1);

	addr_t            line_addr;  // next line to ask for
	logic [1:0]       first_off;  // entry halfword of a new stream
	logic [CNT_W-1:0] credits;
	logic             started;    // low in reset and the first cycle out of it

	// no request in a redirect cycle; the target goes out next cycle
	assign req_valid = started && (credits != '0) && !redirect;

	assign req.addr          = line_addr;
	assign req.tag.epoch     = epoch;
	assign req.tag.hw_offset = first_off;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			started <= 1'b0;
		else
			started <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_addr <= {RESET_PC[31:3], 3'b000};
			first_off <= RESET_PC[2:1];
			epoch     <= 1'b0;
		end else if (redirect) begin
			line_addr <= {redirect_pc[31:3], 3'b000};
			first_off <= redirect_pc[2:1];
			epoch     <= ~epoch;  // everything in flight is now stale
		end else if (req_valid) begin
			line_addr <= line_addr + 32'd8;
			first_off <= 2'b00;   // following lines are used whole
		end
	end

	// one credit per line requested and back when the queue retires it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credits <= CNT_W'(FETCH_CREDITS);
		else
			credits <= credits + CNT_W'(line_done) - CNT_W'(req_valid);
	end

	// a retired line always matches an earlier request
	a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
		(credits <= CNT_W'(FETCH_CREDITS)) &&
		!(line_done && (credits == CNT_W'(FETCH_CREDITS))));

endmodule

// File: source/line_queue.sv
`timescale 1ns/1ps

module line_queue #(
	parameter int FETCH_CREDITS = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   resp_valid,
	input  fetch_pkg::fetch_resp_t resp,
	input  logic                   epoch,
	input  logic                   head_take,
	output logic                   head_valid,
	output fetch_pkg::line_t       head_line,
	output logic [1:0]             head_offset,
	output logic                   line_done
);
	import fetch_pkg::*;

	localparam int PTR_W = (FETCH_CREDITS > 1) ? $clog2(FETCH_CREDITS) : 1;
	localparam int CNT_W = $clog2(FETCH_CREDITS + 1);

	fetch_resp_t      entries [FETCH_CREDITS];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             head_stale;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FETCH_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head_line   = entries[rd_ptr].line;
	assign head_offset = entries[rd_ptr].tag.hw_offset;

	// lines of an old epoch drain through the head, one per cycle
	assign head_stale = (count != '0) && (entries[rd_ptr].tag.epoch != epoch);
	assign head_valid = (count != '0) && !head_stale;
	assign line_done  = (head_valid && head_take) || head_stale;

	always_ff @(posedge clk) begin
		if (resp_valid)
			entries[wr_ptr] <= resp;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (resp_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (line_done)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(resp_valid) - CNT_W'(line_done);
		end
	end

	// memory returned more lines than it had credits for
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(resp_valid && (count == CNT_W'(FETCH_CREDITS))));

endmodule

// File: source/halfword_buffer.sv
`timescale 1ns/1ps

module halfword_buffer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               redirect,
	input  logic               head_valid,
	input  fetch_pkg::line_t   head_line,
	input  logic [1:0]         head_offset,
	input  logic [2:0]         consume_hw,
	output logic               head_take,
	output logic [239:0]       buf_data,
	output fetch_pkg::hw_ptr_t wr_ptr
);
	import fetch_pkg::*;

	localparam int BUF_W = BUF_HWORDS * 16;

	logic [BUF_W-1:0] buf_q;         // halfword 0 is the oldest parcel
	logic [BUF_W-1:0] shifted;       // survivors moved down to halfword 0
	logic [BUF_W-1:0] line_ext;      // head line placed at the fill point
	logic [BUF_W-1:0] buf_nxt;
	line_t            line_aligned;  // useful halfwords moved to the bottom
	logic [4:0]       kept;          // halfwords left after consumption
	logic [2:0]       line_len;      // useful halfwords of the head line
	logic [4:0]       fill_end;

	assign buf_data = buf_q;

	assign kept     = {1'b0, wr_ptr} - {2'b00, consume_hw};
	assign line_len = 3'(LINE_HWORDS) - {1'b0, head_offset};
	assign fill_end = kept + {2'b00, line_len};

	// whole line or nothing by the room left after this cycle
	assign head_take = head_valid && (fill_end <= 5'(BUF_HWORDS));

	assign shifted      = buf_q >> {consume_hw, 4'b0000};
	assign line_aligned = head_line >> {head_offset, 4'b0000};
	assign line_ext     = BUF_W'(line_aligned) << {kept, 4'b0000};

	// survivors below kept and the next line_len halfwords from the line
	always_comb begin
		buf_nxt = shifted;
		for (int i = 0; i < BUF_HWORDS; i++) begin
			if (head_take && (5'(i) >= kept) && (5'(i) < fill_end))
				buf_nxt[i*16 +: 16] = line_ext[i*16 +: 16];
		end
	end

	always_ff @(posedge clk) begin
		buf_q <= buf_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_ptr <= '0;
		else if (redirect)
			wr_ptr <= '0;                    // old stream is thrown away
		else if (head_take)
			wr_ptr <= hw_ptr_t'(fill_end);
		else
			wr_ptr <= hw_ptr_t'(kept);
	end

	// the issue side never takes parcels that are not there
	a_no_overdraw: assert property (@(posedge clk) disable iff (!rst_n)
		kept <= 5'(BUF_HWORDS));

endmodule

// File: source/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
	parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   redirect,
	input  fetch_pkg::addr_t       redirect_pc,
	input  logic [239:0]           buf_data,
	input  fetch_pkg::hw_ptr_t     wr_ptr,
	input  logic                   slot0_ready,
	input  logic                   slot1_ready,
	output fetch_pkg::issue_slot_t slot0,
	output fetch_pkg::issue_slot_t slot1,
	output logic [2:0]             consume_hw
);
	import fetch_pkg::*;

	hword_t     hw0;
	hword_t     hw1;
	hword_t     hw2;
	hword_t     hw3;
	hword_t     slot1_first;  // first parcel of slot1
	logic       is_c0;
	logic       is_c1;
	logic [2:0] len0;         // in halfwords
	logic [2:0] len1;
	logic       take0;
	logic       take1;
	addr_t      pc_q;         // pc of the parcel at halfword 0

	assign hw0 = buf_data[15:0];
	assign hw1 = buf_data[31:16];
	assign hw2 = buf_data[47:32];
	assign hw3 = buf_data[63:48];

	// anything but 2'b11 in the low bits is a compressed instruction
	assign is_c0       = (hw0[1:0] != 2'b11);
	assign len0        = is_c0 ? 3'd1 : 3'd2;
	assign slot1_first = is_c0 ? hw1 : hw2;
	assign is_c1       = (slot1_first[1:0] != 2'b11);
	assign len1        = is_c1 ? 3'd1 : 3'd2;

	assign slot0.valid = (wr_ptr >= 4'd2) || ((wr_ptr == 4'd1) && is_c0);
	assign slot0.pc    = pc_q;
	assign slot0.instr = {hw1, hw0};

	assign slot1.valid = slot0.valid && (wr_ptr >= ({1'b0, len0} + {1'b0, len1}));
	assign slot1.pc    = pc_q + (is_c0 ? 32'd2 : 32'd4);
	assign slot1.instr = is_c0 ? {hw2, hw1} : {hw3, hw2};

	assign take0 = slot0.valid && slot0_ready;
	assign take1 = take0 && slot1.valid && slot1_ready;  // slot1 only behind slot0

	assign consume_hw = (take0 ? len0 : 3'd0) + (take1 ? len1 : 3'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc_q <= RESET_PC;
		else if (redirect)
			pc_q <= redirect_pc;  // wins over whatever was consumed
		else
			pc_q <= pc_q + {28'd0, consume_hw, 1'b0};
	end

	// a stalled slot0 holds while new lines are appended behind it
	// upper parcel of a compressed slot0 may still fill in
	a_slot0_hold: assert property (@(posedge clk) disable iff (!rst_n)
		slot0.valid && !slot0_ready && !redirect |=>
		slot0.valid && $stable(slot0.pc) && $stable(slot0.instr[15:0]) &&
		(is_c0 || $stable(slot0.instr[31:16])));

endmodule

// File: source/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top #(
	parameter fetch_pkg::addr_t RESET_PC      = 32'h0000_1000,
	parameter int               FETCH_CREDITS = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   redirect,
	input  fetch_pkg::addr_t       redirect_pc,
	output logic                   req_valid,
	output fetch_pkg::fetch_req_t  req,
	input  logic                   resp_valid,
	input  fetch_pkg::fetch_resp_t resp,
	output fetch_pkg::issue_slot_t slot0,
	input  logic                   slot0_ready,
	output fetch_pkg::issue_slot_t slot1,
	input  logic                   slot1_ready
);
	import fetch_pkg::*;

	logic         epoch;
	logic         line_done;    // credit back to the address side
	logic         head_valid;
	line_t        head_line;
	logic [1:0]   head_offset;
	logic         head_take;
	logic [239:0] buf_data;
	hw_ptr_t      wr_ptr;
	logic [2:0]   consume_hw;

	fetch_addr_gen #(.RESET_PC(RESET_PC), .FETCH_CREDITS(FETCH_CREDITS)) u_addr_gen (
		.clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
		.line_done(line_done), .req_valid(req_valid), .req(req), .epoch(epoch)
	);

	line_queue #(.FETCH_CREDITS(FETCH_CREDITS)) u_line_queue (
		.clk(clk), .rst_n(rst_n), .resp_valid(resp_valid), .resp(resp), .epoch(epoch),
		.head_take(head_take), .head_valid(head_valid), .head_line(head_line),
		.head_offset(head_offset), .line_done(line_done)
	);

	halfword_buffer u_hw_buffer (
		.clk(clk), .rst_n(rst_n), .redirect(redirect), .head_valid(head_valid),
		.head_line(head_line), .head_offset(head_offset), .consume_hw(consume_hw),
		.head_take(head_take), .buf_data(buf_data), .wr_ptr(wr_ptr)
	);

	issue_select #(.RESET_PC(RESET_PC)) u_issue (
		.clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
		.buf_data(buf_data), .wr_ptr(wr_ptr), .slot0_ready(slot0_ready),
		.slot1_ready(slot1_ready), .slot0(slot0), .slot1(slot1), .consume_hw(consume_hw)
	);

endmodule

// File: tb/fetch_tb_model.svh
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

// instruction memory contents, a hash of the halfword address
function automatic hword_t mem_hword(input addr_t a);
	logic [31:0] x;
	x = a * 32'h9e37_79b1;
	x = x ^ (x >> 15);
	if (x[20])
		return {x[15:2], 2'b11};          // start of a 32-bit instruction
	return {x[15:2], (x[1:0] == 2'b11) ? 2'b01 : x[1:0]};
endfunction

function automatic line_t mem_line(input addr_t a);
	return {mem_hword(a + 32'd6), mem_hword(a + 32'd4),
		mem_hword(a + 32'd2), mem_hword(a)};
endfunction

function automatic logic is_compressed(input addr_t pc);
	hword_t h;
	h = mem_hword(pc);
	return h[1:0] != 2'b11;
endfunction

function automatic instr_t expect_instr(input addr_t pc);
	return {mem_hword(pc + 32'd2), mem_hword(pc)};
endfunction

// pc of the instruction that follows the one at pc
function automatic addr_t next_pc(input addr_t pc);
	return pc + (is_compressed(pc) ? 32'd2 : 32'd4);
endfunction

`endif

// File: tb/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb;
	import fetch_pkg::*;

	localparam addr_t RESET_PC      = 32'h0000_1000;
	localparam int    FETCH_CREDITS = 2;
	localparam int    TEST_CYCLES   = 3000;
	localparam int    STALL_START   = 400;  // offset in each 500-cycle round
	localparam int    STALL_LEN     = 30;
	localparam int    REDIR_GAP     = 8;    // epoch bit cannot wrap onto a line in flight

	`include "fetch_tb_model.svh"

	logic        clk;
	logic        rst_n;
	logic        redirect;
	addr_t       redirect_pc;
	logic        req_valid;
	fetch_req_t  req;
	logic        resp_valid;
	fetch_resp_t resp;
	issue_slot_t slot0;
	issue_slot_t slot1;
	logic        slot0_ready;
	logic        slot1_ready;

	integer      seed;
	addr_t       q_addr[$];  // requests waiting at the memory side
	fetch_tag_t  q_tag[$];
	int          q_due[$];
	int          last_due;
	int          outstanding;

	fetch_buffer_top #(
		.RESET_PC(RESET_PC), .FETCH_CREDITS(FETCH_CREDITS)
	) fetch_buffer_top_inst (
		.clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
		.req_valid(req_valid), .req(req), .resp_valid(resp_valid), .resp(resp),
		.slot0(slot0), .slot0_ready(slot0_ready), .slot1(slot1), .slot1_ready(slot1_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#((TEST_CYCLES + 8 + 200) * 40);
		$display("TIMEOUT: the test did not finish in the expected time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [64:0] expected,
		input logic [64:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// a compressed slot only defines its low parcel
	task automatic check_slot(input string name, input issue_slot_t s, input addr_t pc);
		instr_t exp_i;
		exp_i = expect_instr(pc);
		check_value({name, " pc"}, pc, s.pc);
		if (is_compressed(pc))
			check_value({name, " instr"}, exp_i[15:0], s.instr[15:0]);
		else
			check_value({name, " instr"}, exp_i, s.instr);
	endtask

	initial begin
		int          cyc;
		int          phase;
		logic        stall;
		logic        take0;
		logic        take1;
		logic        after_redirect;
		addr_t       exp_pc;
		addr_t       exp_req_addr;
		logic [1:0]  exp_req_off;
		logic        exp_epoch;
		int          last_redir;
		issue_slot_t held0;
		issue_slot_t held1;
		int          due;

		seed        = 32'h1a3812c1;
		rst_n       = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		resp_valid  = 1'b0;
		resp        = '0;
		slot0_ready = 1'b0;
		slot1_ready = 1'b0;
		last_due    = -1;
		outstanding = 0;

		repeat (8) begin
			#10;
			check_value("reset req_valid", 0, req_valid);
			check_value("reset slot0 valid", 0, slot0.valid);
			check_value("reset slot1 valid", 0, slot1.valid);
			@(negedge clk);
		end
		rst_n          = 1'b1;
		exp_pc         = RESET_PC;
		exp_req_addr   = {RESET_PC[31:3], 3'b000};
		exp_req_off    = RESET_PC[2:1];
		exp_epoch      = 1'b0;
		last_redir     = 0;
		after_redirect = 1'b1;  // slots must also be empty right after reset

		for (cyc = 0; cyc < TEST_CYCLES; cyc++) begin
			phase = cyc % 500;
			stall = (phase >= STALL_START) && (phase < STALL_START + STALL_LEN);

			redirect    = !stall && (cyc - last_redir >= REDIR_GAP) &&
				(({$random(seed)} % 40) == 0);
			redirect_pc = $random(seed) & 32'hffff_fffe;
			slot0_ready = !stall && (({$random(seed)} % 4) != 0);
			slot1_ready = !stall && (({$random(seed)} % 4) != 0);

			// memory answers in order once the head is due
			if (q_due.size() > 0 && q_due[0] <= cyc) begin
				resp_valid = 1'b1;
				resp.line  = mem_line(q_addr[0]);
				resp.tag   = q_tag[0];
				void'(q_addr.pop_front());
				void'(q_tag.pop_front());
				void'(q_due.pop_front());
				outstanding--;
			end else begin
				resp_valid = 1'b0;
			end

			#10;  // combinational outputs settled

			if (cyc == 0)
				check_value("first cycle req_valid", 0, req_valid);

			if (after_redirect) begin
				check_value("empty slot0 valid", 0, slot0.valid);
				check_value("empty slot1 valid", 0, slot1.valid);
				after_redirect = 1'b0;
			end

			if (req_valid) begin
				check_value("req addr", exp_req_addr, req.addr);
				check_value("req tag", {exp_epoch, exp_req_off}, req.tag);
				exp_req_addr = exp_req_addr + 32'd8;
				exp_req_off  = 2'b00;
				due = cyc + 1 + ({$random(seed)} % 4);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				q_addr.push_back(req.addr);
				q_tag.push_back(req.tag);
				q_due.push_back(due);
				outstanding++;
			end
			check_value("outstanding bound", 1, outstanding <= 2 * FETCH_CREDITS);

			// buffer and queue are full this late in a stall window
			if (phase == STALL_START + STALL_LEN - 4) begin
				held0 = slot0;
				held1 = slot1;
			end
			if (stall && phase > STALL_START + STALL_LEN - 4) begin
				check_value("stall slot0 held", held0, slot0);
				check_value("stall slot1 held", held1, slot1);
			end
			if (phase == STALL_START + STALL_LEN - 1)
				check_value("stall req_valid", 0, req_valid);

			if (redirect) begin
				check_value("redirect cycle req_valid", 0, req_valid);
				exp_pc         = redirect_pc;  // consumption this cycle is void
				exp_req_addr   = {redirect_pc[31:3], 3'b000};
				exp_req_off    = redirect_pc[2:1];
				exp_epoch      = ~exp_epoch;
				last_redir     = cyc;
				after_redirect = 1'b1;
			end else begin
				take0 = slot0.valid && slot0_ready;
				take1 = take0 && slot1.valid && slot1_ready;
				if (take0) begin
					check_slot("slot0", slot0, exp_pc);
					exp_pc = next_pc(exp_pc);
				end
				if (take1) begin
					check_slot("slot1", slot1, exp_pc);
					exp_pc = next_pc(exp_pc);
				end
			end

			@(negedge clk);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+tb
source/fetch_pkg.sv
source/fetch_addr_gen.sv
source/line_queue.sv
source/halfword_buffer.sv
source/issue_select.sv
source/fetch_buffer_top.sv
tb/fetch_buffer_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fetch_buffer_tb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | grep "Simulation PASSED"

clean:
	rm -rf obj_dir
